/* hw/ex_pkg.sv */
//////////////////////////////
// Shared definitions for the execute stage
// Data and register-address widths, the word and address types,
// and the ALU and multiplier opcodes
// Every RTL file refers to these by scoped names
//////////////////////////////

`default_nettype none

package ex_pkg;

  // Data word and register file sizes
  localparam int xlen       = 32;
  localparam int reg_addr_w = 6;
  localparam int shamt_w    = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // Most negative signed word, start value of the running max
  localparam word_t word_min = {1'b1, {(xlen-1){1'b0}}};

  // ALU operations, the last four only drive the comparison flag
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13
  } alu_op_e;

  // Multiplier operations, low product and the three high products
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mul_op_e;

endpackage

`default_nettype wire

/* hw/ex_alu.sv */
//////////////////////////////
// Single-cycle integer ALU
// Arithmetic, logic, shifts and set-less-than on result_o
// Comparison opcodes raise cmp_o, used as the branch decision
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_o
);

  // Shift amount from the low bits of operand b
  logic [ex_pkg::shamt_w-1:0] shamt;

  assign shamt = operand_b_i[ex_pkg::shamt_w-1:0];

  always_comb begin
    result_o = '0;
    cmp_o    = 1'b0;
    case (operator_i)
      ex_pkg::ALU_ADD: result_o = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB: result_o = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::ALU_SRA: result_o = ex_pkg::word_t'($signed(operand_a_i) >>> shamt);
      ex_pkg::ALU_SLT: begin
        cmp_o    = $signed(operand_a_i) < $signed(operand_b_i);
        result_o = {{(ex_pkg::xlen-1){1'b0}}, cmp_o};
      end
      ex_pkg::ALU_SLTU: begin
        cmp_o    = operand_a_i < operand_b_i;
        result_o = {{(ex_pkg::xlen-1){1'b0}}, cmp_o};
      end
      // Branch comparisons, result stays zero
      ex_pkg::ALU_EQ: cmp_o = (operand_a_i == operand_b_i);
      ex_pkg::ALU_NE: cmp_o = (operand_a_i != operand_b_i);
      ex_pkg::ALU_LT: cmp_o = $signed(operand_a_i) < $signed(operand_b_i);
      ex_pkg::ALU_GE: cmp_o = $signed(operand_a_i) >= $signed(operand_b_i);
      default: begin
        result_o = '0;
        cmp_o    = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/ex_cumulative.sv */
//////////////////////////////
// Product accumulator
// Adds a_i * b_i (low word) on each enabled edge
// clr_i empties it and wins over en_i
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex_cumulative (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          clr_i,
  input  logic          en_i,
  input  ex_pkg::word_t a_i,
  input  ex_pkg::word_t b_i,
  output ex_pkg::word_t result_o
);

  ex_pkg::word_t acc_q;
  // Low word of the product only, upper half is dropped
  ex_pkg::word_t prod;

  assign prod = a_i * b_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (clr_i) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= acc_q + prod;
    end
  end

  // A get reads the sum before this cycle's update
  assign result_o = acc_q;

endmodule

`default_nettype wire

/* hw/ex_max.sv */
//////////////////////////////
// Running signed maximum
// Each enabled edge keeps the largest of the register, a_i and b_i
// clr_i brings it back to the most negative word
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex_max (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          clr_i,
  input  logic          en_i,
  input  ex_pkg::word_t a_i,
  input  ex_pkg::word_t b_i,
  output ex_pkg::word_t result_o
);

  ex_pkg::word_t max_q;
  ex_pkg::word_t ab_max;
  ex_pkg::word_t next_max;

  always_comb begin
    // Larger operand first, then against the stored value
    ab_max   = ($signed(a_i) > $signed(b_i)) ? a_i : b_i;
    next_max = ($signed(ab_max) > $signed(max_q)) ? ab_max : max_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      max_q <= ex_pkg::word_min;
    end else if (clr_i) begin
      max_q <= ex_pkg::word_min;
    end else if (en_i) begin
      max_q <= next_max;
    end
  end

  assign result_o = max_q;

endmodule

`default_nettype wire

/* hw/ex_mult.sv */
//////////////////////////////
// 32x32 multiplier
// MUL_LO returns the low word in the same cycle
// High products are registered and show up one cycle later,
// ready_o is low in the first cycle of a high product
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            en_i,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  input  logic            ex_ready_i,
  output ex_pkg::word_t   result_o,
  output logic            ready_o,
  output logic            multicycle_o
);

  logic                               is_high;
  logic                               sign_a;
  logic                               sign_b;
  logic signed [ex_pkg::xlen:0]       a_ext;
  logic signed [ex_pkg::xlen:0]       b_ext;
  logic signed [2*ex_pkg::xlen-1:0]   prod;
  logic                               stage_q;
  ex_pkg::word_t                      hi_q;

  // Operand signedness per opcode
  assign is_high = (operator_i != ex_pkg::MUL_LO);
  assign sign_a  = (operator_i == ex_pkg::MUL_H) || (operator_i == ex_pkg::MUL_HSU);
  assign sign_b  = (operator_i == ex_pkg::MUL_H);

  // One extra bit so unsigned operands stay positive
  assign a_ext = $signed({sign_a & op_a_i[ex_pkg::xlen-1], op_a_i});
  assign b_ext = $signed({sign_b & op_b_i[ex_pkg::xlen-1], op_b_i});
  assign prod  = a_ext * b_ext;

  ////////////////////////////// 
  // High product stage
  //////////////////////////////

  // Set on the first cycle of a high op, held until EX moves on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= 1'b0;
    end else if (stage_q) begin
      if (ex_ready_i) stage_q <= 1'b0;
    end else if (en_i && is_high) begin
      stage_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (en_i && is_high && !stage_q) hi_q <= prod[2*ex_pkg::xlen-1:ex_pkg::xlen];
  end

  assign multicycle_o = en_i & is_high & ~stage_q;
  assign ready_o      = ~multicycle_o;
  assign result_o     = is_high ? hi_q : prod[ex_pkg::xlen-1:0];

  // Idle multiplier never stalls the stage
  a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n) !en_i |-> ready_o);
  // Decoder keeps the high op in EX until its result is taken
  a_op_held: assert property (@(posedge clk) disable iff (!rst_n)
    stage_q |-> en_i && is_high);

endmodule

`default_nettype wire

/* hw/ex_ctrl.sv */
//////////////////////////////
// Execute stage control
// Picks the forwarding write data, holds the EX/WB register
// for load writebacks and derives ex_ready and ex_valid
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              cml_en_i,
  input  logic              cml_get_i,
  input  logic              max_en_i,
  input  logic              max_get_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  logic              mult_ready_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     cml_result_i,
  input  ex_pkg::word_t     max_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic              cml_sel;
  logic              max_sel;
  logic              units_ready;
  logic              lsu_we;
  logic              we_q;
  ex_pkg::reg_addr_t waddr_q;

  assign cml_sel = cml_en_i | cml_get_i;
  assign max_sel = max_en_i | max_get_i;

  ////////////////////////////// 
  // Forwarding port
  //////////////////////////////

  // Later selects override earlier ones
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i)     regfile_alu_wdata_fw_o = alu_result_i;
    if (cml_sel)      regfile_alu_wdata_fw_o = cml_result_i;
    if (max_sel)      regfile_alu_wdata_fw_o = max_result_i;
    if (mult_en_i)    regfile_alu_wdata_fw_o = mult_result_i;
    if (csr_access_i) regfile_alu_wdata_fw_o = csr_rdata_i;
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  ////////////////////////////// 
  // EX/WB register
  //////////////////////////////

  // Faulting loads never write back
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (ex_valid_o) begin
      we_q <= lsu_we;
      if (lsu_we) waddr_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      // Nothing new, flush the slot
      we_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Branches finish in EX without needing WB
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Decoder drives at most one result source per instruction
  a_one_src: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, cml_sel, max_sel, mult_en_i, csr_access_i}));

endmodule

`default_nettype wire

/* hw/ex_stage.sv */
//////////////////////////////
// Execute stage top level
// ALU, accumulator, running max and multiplier feed the
// stage control, which drives the forwarding and WB ports
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  input  logic              alu_en_i,
  // Accumulator
  input  ex_pkg::word_t     cml_operand_a_i,
  input  ex_pkg::word_t     cml_operand_b_i,
  input  logic              cml_en_i,
  input  logic              cml_get_i,
  input  logic              cml_rst_i,
  // Running max
  input  ex_pkg::word_t     max_operand_a_i,
  input  ex_pkg::word_t     max_operand_b_i,
  input  logic              max_en_i,
  input  logic              max_get_i,
  input  logic              max_rst_i,
  // Multiplier
  input  ex_pkg::mul_op_e   mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  logic              mult_en_i,
  output logic              mult_multicycle_o,
  // LSU, CSR and register file controls from ID
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // Forwarding port to ID
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  // Load writeback port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  // Jump and branch to IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  // Stall control
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::word_t alu_result;
  ex_pkg::word_t cml_result;
  ex_pkg::word_t max_result;
  ex_pkg::word_t mult_result;
  logic          mult_ready;

  // Target computed in ID, passed on unchanged
  assign jump_target_o = alu_operand_c_i;

  ex_alu u_alu (
    .operator_i  (alu_operator_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .result_o    (alu_result),
    .cmp_o       (branch_decision_o)
  );

  ex_cumulative u_cml (
    .clk      (clk),
    .rst_n    (rst_n),
    .clr_i    (cml_rst_i),
    .en_i     (cml_en_i),
    .a_i      (cml_operand_a_i),
    .b_i      (cml_operand_b_i),
    .result_o (cml_result)
  );

  ex_max u_max (
    .clk      (clk),
    .rst_n    (rst_n),
    .clr_i    (max_rst_i),
    .en_i     (max_en_i),
    .a_i      (max_operand_a_i),
    .b_i      (max_operand_b_i),
    .result_o (max_result)
  );

  // Stage ready loops back so a high product waits for EX to move
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_ctrl u_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .cml_en_i               (cml_en_i),
    .cml_get_i              (cml_get_i),
    .max_en_i               (max_en_i),
    .max_get_i              (max_get_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_we_i           (regfile_we_i),
    .mult_ready_i           (mult_ready),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .alu_result_i           (alu_result),
    .cml_result_i           (cml_result),
    .max_result_i           (max_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

/* tests/tb_ex_stage.sv */
//////////////////////////////
// Testbench for the execute stage top level
// Builds a table of operations with expected results from a
// reference model fed by an LCG, then applies it entry by entry
// Stops at the first mismatch, a watchdog bounds the run
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_ex_stage;

  // Unit selected by a table entry
  typedef enum logic [3:0] {
    K_ALU, K_MUL, K_CML, K_CML_GET, K_CML_CLR, K_MAX, K_MAX_GET, K_MAX_CLR,
    K_LSU, K_CSR, K_STALL
  } kind_e;

  // Operands, LSU error flag, address and expected results
  typedef struct packed {
    kind_e             kind;
    logic [3:0]        op;
    ex_pkg::word_t     a;
    ex_pkg::word_t     b;
    ex_pkg::word_t     c;
    logic              flag;
    ex_pkg::reg_addr_t addr;
    ex_pkg::word_t     exp_w;
    logic              exp_b;
  } entry_t;

  logic              clk;
  logic              rst_n;
  ex_pkg::alu_op_e   alu_operator_i;
  ex_pkg::word_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic              alu_en_i;
  ex_pkg::word_t     cml_operand_a_i, cml_operand_b_i;
  logic              cml_en_i, cml_get_i, cml_rst_i;
  ex_pkg::word_t     max_operand_a_i, max_operand_b_i;
  logic              max_en_i, max_get_i, max_rst_i;
  ex_pkg::mul_op_e   mult_operator_i;
  ex_pkg::word_t     mult_operand_a_i, mult_operand_b_i;
  logic              mult_en_i, mult_multicycle_o;
  logic              lsu_en_i, lsu_ready_ex_i, lsu_err_i;
  ex_pkg::word_t     lsu_rdata_i, csr_rdata_i;
  logic              csr_access_i, branch_in_ex_i;
  logic              regfile_alu_we_i, regfile_we_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic              regfile_alu_we_fw_o, regfile_we_wb_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  ex_pkg::word_t     regfile_alu_wdata_fw_o, regfile_wdata_wb_o;
  ex_pkg::word_t     jump_target_o;
  logic              branch_decision_o;
  logic              wb_ready_i, ex_ready_o, ex_valid_o;

  entry_t        tbl[$];
  logic          table_built = 1'b0;
  ex_pkg::word_t lcg_state   = 32'd1322;

  ex_stage dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic ex_pkg::word_t rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Signed compare from the sign bits, unsigned when they agree
  function automatic logic signed_less(input ex_pkg::word_t a, input ex_pkg::word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic ex_pkg::word_t alu_ref(input logic [3:0] op, input ex_pkg::word_t a,
                                            input ex_pkg::word_t b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << b[4:0];
      ex_pkg::ALU_SRL:  return a >> b[4:0];
      ex_pkg::ALU_SRA:  return ext[31:0];
      ex_pkg::ALU_SLT:  return {31'b0, signed_less(a, b)};
      ex_pkg::ALU_SLTU: return {31'b0, a < b};
      default:          return '0;
    endcase
  endfunction

  function automatic logic cmp_ref(input logic [3:0] op, input ex_pkg::word_t a,
                                   input ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_SLT, ex_pkg::ALU_LT: return signed_less(a, b);
      ex_pkg::ALU_SLTU: return a < b;
      ex_pkg::ALU_EQ:   return a == b;
      ex_pkg::ALU_NE:   return a != b;
      ex_pkg::ALU_GE:   return !signed_less(a, b);
      default:          return 1'b0;
    endcase
  endfunction

  // 64-bit product of the extended operands, low or high half
  function automatic ex_pkg::word_t mul_ref(input logic [1:0] op, input ex_pkg::word_t a,
                                            input ex_pkg::word_t b);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = (op == ex_pkg::MUL_H || op == ex_pkg::MUL_HSU) ? {{32{a[31]}}, a} : {32'b0, a};
    xb = (op == ex_pkg::MUL_H) ? {{32{b[31]}}, b} : {32'b0, b};
    p  = xa * xb;
    return (op == ex_pkg::MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  function automatic entry_t make_entry(input kind_e kind, input logic [3:0] op,
      input ex_pkg::word_t a, input ex_pkg::word_t b, input ex_pkg::word_t c,
      input logic flag, input ex_pkg::reg_addr_t addr, input ex_pkg::word_t exp_w,
      input logic exp_b);
    entry_t e;
    e.kind  = kind;
    e.op    = op;
    e.a     = a;
    e.b     = b;
    e.c     = c;
    e.flag  = flag;
    e.addr  = addr;
    e.exp_w = exp_w;
    e.exp_b = exp_b;
    return e;
  endfunction

  task automatic build_table();
    ex_pkg::word_t a, b, c, acc, mx;
    int op, k;
    acc = '0;
    mx  = 32'h8000_0000;
    // Every ALU opcode, third pass with equal operands
    for (op = 0; op < 14; op++) begin
      for (k = 0; k < 3; k++) begin
        a = rand_word();
        b = (k == 2) ? a : rand_word();
        c = rand_word();
        tbl.push_back(make_entry(K_ALU, 4'(op), a, b, c, 1'b0, c[5:0],
                                 alu_ref(4'(op), a, b), cmp_ref(4'(op), a, b)));
      end
    end
    for (op = 0; op < 4; op++) begin
      for (k = 0; k < 3; k++) begin
        a = rand_word();
        b = rand_word();
        tbl.push_back(make_entry(K_MUL, 4'(op), a, b, '0, 1'b0, '0,
                                 mul_ref(2'(op), a, b), 1'b0));
      end
    end
    // Accumulator shows the sum before the enabled edge
    for (k = 0; k < 4; k++) begin
      a = rand_word();
      b = rand_word();
      tbl.push_back(make_entry(K_CML, '0, a, b, '0, 1'b0, '0, acc, 1'b0));
      acc = acc + a * b;
    end
    tbl.push_back(make_entry(K_CML_GET, '0, '0, '0, '0, 1'b0, '0, acc, 1'b0));
    tbl.push_back(make_entry(K_CML_CLR, '0, '0, '0, '0, 1'b0, '0, '0, 1'b0));
    tbl.push_back(make_entry(K_CML_GET, '0, '0, '0, '0, 1'b0, '0, '0, 1'b0));
    for (k = 0; k < 4; k++) begin
      a = rand_word();
      b = rand_word();
      tbl.push_back(make_entry(K_MAX, '0, a, b, '0, 1'b0, '0, mx, 1'b0));
      if (signed_less(mx, a)) mx = a;
      if (signed_less(mx, b)) mx = b;
    end
    tbl.push_back(make_entry(K_MAX_GET, '0, '0, '0, '0, 1'b0, '0, mx, 1'b0));
    tbl.push_back(make_entry(K_MAX_CLR, '0, '0, '0, '0, 1'b0, '0, '0, 1'b0));
    tbl.push_back(make_entry(K_MAX_GET, '0, '0, '0, '0, 1'b0, '0, 32'h8000_0000, 1'b0));
    // Loads, the middle one faults and must not write back
    for (k = 0; k < 3; k++) begin
      a = rand_word();
      b = rand_word();
      tbl.push_back(make_entry(K_LSU, '0, a, '0, '0, (k == 1), b[5:0], '0, (k != 1)));
    end
    for (k = 0; k < 2; k++) begin
      a = rand_word();
      tbl.push_back(make_entry(K_CSR, '0, a, '0, '0, 1'b0, '0, a, 1'b0));
    end
    a = rand_word();
    b = rand_word();
    tbl.push_back(make_entry(K_STALL, '0, a, '0, '0, 1'b0, b[5:0], '0, 1'b1));
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic fail_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input ex_pkg::word_t got,
                            input ex_pkg::word_t exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got=0x%08h expected=0x%08h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got=%b expected=%b", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_addr(input string name, input ex_pkg::reg_addr_t got,
                            input ex_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got=0x%02h expected=0x%02h", $time, name, got, exp);
      fail_run();
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // All strobes low and every consumer ready, data inputs kept
  task automatic drive_idle();
    alu_en_i         <= 1'b0;
    cml_en_i         <= 1'b0;
    cml_get_i        <= 1'b0;
    cml_rst_i        <= 1'b0;
    max_en_i         <= 1'b0;
    max_get_i        <= 1'b0;
    max_rst_i        <= 1'b0;
    mult_en_i        <= 1'b0;
    lsu_en_i         <= 1'b0;
    lsu_err_i        <= 1'b0;
    lsu_ready_ex_i   <= 1'b1;
    csr_access_i     <= 1'b0;
    branch_in_ex_i   <= 1'b0;
    regfile_alu_we_i <= 1'b0;
    regfile_we_i     <= 1'b0;
    wb_ready_i       <= 1'b1;
  endtask

  task automatic apply_entry(input entry_t e);
    int   cycles;
    int   exp_cycles;
    logic waits;
    waits      = (e.kind inside {K_ALU, K_MUL, K_LSU, K_CSR, K_STALL});
    exp_cycles = (e.op[1:0] == ex_pkg::MUL_LO) ? 1 : 2;
    @(posedge clk);
    case (e.kind)
      K_ALU: begin
        alu_en_i            <= 1'b1;
        alu_operator_i      <= ex_pkg::alu_op_e'(e.op);
        alu_operand_a_i     <= e.a;
        alu_operand_b_i     <= e.b;
        alu_operand_c_i     <= e.c;
        regfile_alu_we_i    <= 1'b1;
        regfile_alu_waddr_i <= e.addr;
      end
      K_MUL: begin
        mult_en_i        <= 1'b1;
        mult_operator_i  <= ex_pkg::mul_op_e'(e.op[1:0]);
        mult_operand_a_i <= e.a;
        mult_operand_b_i <= e.b;
      end
      K_CML: begin
        cml_en_i        <= 1'b1;
        cml_operand_a_i <= e.a;
        cml_operand_b_i <= e.b;
      end
      K_CML_GET: cml_get_i <= 1'b1;
      K_CML_CLR: cml_rst_i <= 1'b1;
      K_MAX: begin
        max_en_i        <= 1'b1;
        max_operand_a_i <= e.a;
        max_operand_b_i <= e.b;
      end
      K_MAX_GET: max_get_i <= 1'b1;
      K_MAX_CLR: max_rst_i <= 1'b1;
      K_CSR: begin
        csr_access_i <= 1'b1;
        csr_rdata_i  <= e.a;
      end
      default: begin
        // Load, the stall variant meets back-pressure once accepted
        lsu_en_i        <= 1'b1;
        lsu_err_i       <= e.flag;
        lsu_rdata_i     <= e.a;
        regfile_we_i    <= 1'b1;
        regfile_waddr_i <= e.addr;
      end
    endcase
    @(negedge clk);
    cycles = 1;
    if (e.kind == K_STALL) begin
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
      // WB stalls right after the capture, a new address is pending
      @(posedge clk);
      wb_ready_i      <= 1'b0;
      regfile_waddr_i <= ~e.addr;
      @(negedge clk);
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
      check_bit("ex_ready_o", ex_ready_o, 1'b0);
      check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
      check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, e.addr);
      @(posedge clk);
      branch_in_ex_i <= 1'b1;
      @(negedge clk);
      // Branch in EX keeps the stage ready under back-pressure
      check_bit("ex_ready_o", ex_ready_o, 1'b1);
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
      check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
      check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, e.addr);
      @(posedge clk);
      branch_in_ex_i  <= 1'b0;
      wb_ready_i      <= 1'b1;
      regfile_waddr_i <= e.addr;
      @(negedge clk);
    end
    if (e.kind == K_MUL && exp_cycles == 2) begin
      check_bit("mult_multicycle_o", mult_multicycle_o, 1'b1);
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
    end
    while (waits && !ex_valid_o) begin
      @(negedge clk);
      cycles++;
    end
    case (e.kind)
      K_ALU: begin
        check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, e.exp_w);
        check_bit("branch_decision_o", branch_decision_o, e.exp_b);
        check_word("jump_target_o", jump_target_o, e.c);
        check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, 1'b1);
        check_addr("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw_o, e.addr);
      end
      K_MUL: begin
        if (cycles != exp_cycles) begin
          $display("ex_valid_o rose after %0d cycles instead of %0d at t=%0t",
                   cycles, exp_cycles, $time);
          fail_run();
        end
        check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, e.exp_w);
      end
      K_CML, K_CML_GET, K_MAX, K_MAX_GET, K_CSR: begin
        check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, e.exp_w);
      end
      default: ;
    endcase
    @(posedge clk);
    drive_idle();
    // Writeback shows one cycle after ex_valid_o
    if (e.kind == K_LSU || e.kind == K_STALL) begin
      @(negedge clk);
      check_bit("regfile_we_wb_o", regfile_we_wb_o, e.exp_b);
      if (e.exp_b) begin
        check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, e.addr);
        check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, e.a);
      end
    end
  endtask

  initial begin
    clk                 = 1'b0;
    rst_n               = 1'b0;
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    cml_operand_a_i     = '0;
    cml_operand_b_i     = '0;
    max_operand_a_i     = '0;
    max_operand_b_i     = '0;
    mult_operator_i     = ex_pkg::MUL_LO;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    lsu_rdata_i         = '0;
    csr_rdata_i         = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    drive_idle();
    build_table();
    table_built = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    check_bit("mult_multicycle_o", mult_multicycle_o, 1'b0);
    check_bit("ex_ready_o", ex_ready_o, 1'b1);
    foreach (tbl[i]) apply_entry(tbl[i]);
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Watchdog, bounded by the table length
  initial begin
    wait (table_built);
    repeat (tbl.size() * 4 + 50) @(posedge clk);
    $display("Watchdog timeout, the table did not finish in time");
    fail_run();
  end

endmodule

`default_nettype wire

/* filelist.f */
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_cumulative.sv
hw/ex_max.sv
hw/ex_mult.sv
hw/ex_ctrl.sv
hw/ex_stage.sv
tests/tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
verilator --binary --timing --assert -f filelist.f --top-module tb_ex_stage \
  -o tb_ex_stage > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_ex_stage > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || grep -q "ALL TESTS PASSED" sim.log || exit 1
